//--- Bender.yml
package:
  name: dawg_cache

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/dawg_policy_regs.sv
      - design/cache_set_store.sv
      - design/hit_lookup.sv
      - design/victim_select.sv
      - design/cache_ctrl.sv
      - design/dawg_cache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/cache_properties.sv
      - test/dawg_cache_tb.sv

//--- design/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_ctrl (
  input  wire                                            clk,
  input  wire                                            rst,
  input  var cache_pkg::cpu_req_t                        cpu_req,
  output cache_pkg::cpu_res_t                            cpu_res,
  output cache_pkg::mem_req_t                            mem_req,
  input  var cache_pkg::mem_rsp_t                        mem_rsp,
  input  wire                                            hit,
  input  wire [`CACHE_WAY_BITS-1:0]                      hit_way,
  input  wire [`CACHE_WAY_BITS-1:0]                      victim_way,
  input  wire                                            victim_dirty,
  input  var cache_pkg::tag_entry_t [`CACHE_WAYS-1:0]    tags,
  input  wire [`CACHE_WAYS-1:0][`CACHE_LINE_BITS-1:0]    lines,
  output logic [`CACHE_WAY_BITS-1:0]                     way,
  output logic                                           tag_we,
  output cache_pkg::tag_entry_t                          tag_wdata,
  output logic                                           data_we,
  output logic [`CACHE_LINE_BITS-1:0]                    line_wdata,
  output logic                                           lru_touch,
  output logic [`CACHE_INDEX_BITS-1:0]                   index
);
  import cache_pkg::*;

  ctrl_state_e                   state_q;
  ctrl_state_e                   state_d;
  // way chosen on a miss, held through write_back and allocate
  logic [`CACHE_WAY_BITS-1:0]    way_q;
  // victim line address, the tag entry is overwritten before the write-back
  logic [`CACHE_ADDR_BITS-1:0]   wb_addr_q;

  logic [`CACHE_TAG_BITS-1:0]    req_tag;
  logic [`CACHE_OFFSET_BITS-3:0] word_sel;
  logic [`CACHE_ADDR_BITS-1:0]   line_addr;
  logic [`CACHE_ADDR_BITS-1:0]   victim_addr;
  logic [`CACHE_LINE_BITS-1:0]   sel_line;
  logic [`CACHE_LINE_BITS-1:0]   merged_line;

  // ------------------------------
  // address decode
  // ------------------------------

  assign req_tag   = cpu_req.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
  assign index     = cpu_req.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
  // word within the line, addr bits 3:2
  assign word_sel  = cpu_req.addr[`CACHE_OFFSET_BITS-1:2];
  assign line_addr = {cpu_req.addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS],
                      {`CACHE_OFFSET_BITS{1'b0}}};
  // victim tag with the request index
  assign victim_addr = {tags[victim_way].tag, index, {`CACHE_OFFSET_BITS{1'b0}}};

  // hit way or victim in compare, registered way afterwards
  assign way      = (state_q == st_compare) ? (hit ? hit_way : victim_way) : way_q;
  assign sel_line = lines[way];

  // write hit merges the cpu word into the selected line
  always_comb begin
    merged_line = sel_line;
    merged_line[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] = cpu_req.data;
  end

  // ------------------------------
  // fsm
  // ------------------------------

  always_comb begin
    state_d       = state_q;
    cpu_res.ready = 1'b0;
    cpu_res.data  = sel_line[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
    mem_req.valid = 1'b0;
    mem_req.rw    = 1'b0;
    mem_req.addr  = line_addr;
    // victim line on write-back, otherwise just stable
    mem_req.data  = sel_line;
    tag_we        = 1'b0;
    tag_wdata     = tags[way];
    data_we       = 1'b0;
    line_wdata    = merged_line;
    lru_touch     = 1'b0;
    case (state_q)
      st_idle: begin
        if (cpu_req.valid) begin
          state_d = st_compare;
        end
      end
      st_compare: begin
        // store drops the touch when the way lies outside the fillmap
        lru_touch = 1'b1;
        if (hit) begin
          cpu_res.ready = 1'b1;
          state_d       = st_idle;
          if (cpu_req.rw) begin
            tag_we          = 1'b1;
            data_we         = 1'b1;
            tag_wdata.dirty = 1'b1;
          end
        end else begin
          // claim the victim way with the new tag now
          tag_we          = 1'b1;
          tag_wdata.valid = 1'b1;
          tag_wdata.dirty = cpu_req.rw;
          tag_wdata.tag   = req_tag;
          // an empty way gets the requester as owner
          if (!tags[victim_way].valid) begin
            tag_wdata.owner = cpu_req.domain;
          end
          mem_req.valid = 1'b1;
          if (victim_dirty) begin
            mem_req.rw   = 1'b1;
            mem_req.addr = victim_addr;
            state_d      = st_write_back;
          end else begin
            state_d = st_allocate;
          end
        end
      end
      st_write_back: begin
        mem_req.valid = 1'b1;
        mem_req.rw    = 1'b1;
        mem_req.addr  = wb_addr_q;
        if (mem_rsp.ready) begin
          state_d = st_allocate;
        end
      end
      st_allocate: begin
        mem_req.valid = 1'b1;
        line_wdata    = mem_rsp.data;
        // refill then retry the compare, which now hits
        if (mem_rsp.ready) begin
          data_we = 1'b1;
          state_d = st_compare;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // capture the miss target in the compare cycle
  always_ff @(posedge clk) begin
    if (state_q == st_compare && !hit) begin
      way_q     <= victim_way;
      wb_addr_q <= victim_addr;
    end
  end

endmodule

`default_nettype wire

//--- design/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ------------------------------
// cache geometry
// ------------------------------

// associativity
`define CACHE_WAYS 4
`define CACHE_WAY_BITS 2

// sets and set index
`define CACHE_SETS 16
`define CACHE_INDEX_BITS 4

// byte offset within a 128 bit line
`define CACHE_OFFSET_BITS 4

// datapath widths
`define CACHE_ADDR_BITS 32
`define CACHE_WORD_BITS 32
`define CACHE_LINE_BITS 128
`define CACHE_TAG_BITS 24

// protection domains, one policy entry each
`define CACHE_DOMAIN_BITS 2
`define CACHE_DOMAINS 4

`endif

//--- design/cache_pkg.sv
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

  // one bit per way, used for fillmap and hitmap
  typedef logic [`CACHE_WAYS-1:0] way_mask_t;

  // cpu side request, held stable until ready
  typedef struct packed {
    logic                          valid;
    logic                          rw;
    logic [`CACHE_DOMAIN_BITS-1:0] domain;
    logic [`CACHE_ADDR_BITS-1:0]   addr;
    logic [`CACHE_WORD_BITS-1:0]   data;
  } cpu_req_t;

  // ready is a single cycle pulse
  typedef struct packed {
    logic                        ready;
    logic [`CACHE_WORD_BITS-1:0] data;
  } cpu_res_t;

  // rw high means write-back of a dirty line
  typedef struct packed {
    logic                        valid;
    logic                        rw;
    logic [`CACHE_ADDR_BITS-1:0] addr;
    logic [`CACHE_LINE_BITS-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                        ready;
    logic [`CACHE_LINE_BITS-1:0] data;
  } mem_rsp_t;

  // per way tag entry, owner is the domain that first filled it
  typedef struct packed {
    logic                          valid;
    logic                          dirty;
    logic [`CACHE_DOMAIN_BITS-1:0] owner;
    logic [`CACHE_TAG_BITS-1:0]    tag;
  } tag_entry_t;

  // policy table write port
  typedef struct packed {
    logic                          we;
    logic [`CACHE_DOMAIN_BITS-1:0] domain;
    way_mask_t                     fillmap;
    way_mask_t                     hitmap;
  } policy_cfg_t;

  typedef enum logic [1:0] {
    st_idle,
    st_compare,
    st_allocate,
    st_write_back
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/cache_set_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_set_store (
  input  wire                                            clk,
  input  wire                                            rst,
  input  wire [`CACHE_INDEX_BITS-1:0]                    index,
  output cache_pkg::tag_entry_t [`CACHE_WAYS-1:0]        tags,
  output logic [`CACHE_WAYS-1:0][`CACHE_LINE_BITS-1:0]   lines,
  output logic [`CACHE_WAYS-1:0][`CACHE_WAY_BITS-1:0]    ages,
  input  wire [`CACHE_WAY_BITS-1:0]                      way,
  input  wire                                            tag_we,
  input  var cache_pkg::tag_entry_t                      tag_wdata,
  input  wire                                            data_we,
  input  wire [`CACHE_LINE_BITS-1:0]                     line_wdata,
  input  wire                                            lru_touch,
  input  var cache_pkg::way_mask_t                       fillmap
);
  import cache_pkg::*;

  // ------------------------------
  // storage arrays
  // ------------------------------

  tag_entry_t [`CACHE_WAYS-1:0]                 tag_mem  [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0][`CACHE_LINE_BITS-1:0] line_mem [`CACHE_SETS];
  // age 0 is most recently used, 3 is oldest
  logic [`CACHE_WAYS-1:0][`CACHE_WAY_BITS-1:0]  age_mem  [`CACHE_SETS];

  // move to front results for the indexed set
  logic [`CACHE_WAYS-1:0][`CACHE_WAY_BITS-1:0]  age_next;
  logic [`CACHE_WAY_BITS-1:0]                   touched_age;
  logic                                         lru_en;

  // combinational read of the indexed set
  assign tags  = tag_mem[index];
  assign lines = line_mem[index];
  assign ages  = age_mem[index];

  // ------------------------------
  // lru stack update
  // ------------------------------

  assign touched_age = age_mem[index][way];

  // ways outside the domain's fillmap leave the order untouched
  assign lru_en = lru_touch && fillmap[way];

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (w[`CACHE_WAY_BITS-1:0] == way) begin
        // touched way becomes youngest
        age_next[w] = '0;
      end else if (age_mem[index][w] < touched_age) begin
        // ways younger than the touched one slide back by one
        age_next[w] = age_mem[index][w] + 1'b1;
      end else begin
        age_next[w] = age_mem[index][w];
      end
    end
  end

  // ------------------------------
  // clocked writes
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          // invalid, clean, owner 0
          tag_mem[s][w] <= '0;
          // initial order follows way number
          age_mem[s][w] <= w[`CACHE_WAY_BITS-1:0];
        end
      end
    end else begin
      if (tag_we) begin
        tag_mem[index][way] <= tag_wdata;
      end
      if (lru_en) begin
        age_mem[index] <= age_next;
      end
    end
  end

  // line data, written on refill and on write hits
  always_ff @(posedge clk) begin
    if (data_we) begin
      line_mem[index][way] <= line_wdata;
    end
  end

endmodule

`default_nettype wire

//--- design/dawg_cache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module dawg_cache_top (
  input  wire                         clk,
  input  wire                         rst,
  input  var cache_pkg::cpu_req_t     cpu_req,
  output cache_pkg::cpu_res_t         cpu_res,
  output cache_pkg::mem_req_t         mem_req,
  input  var cache_pkg::mem_rsp_t     mem_rsp,
  input  var cache_pkg::policy_cfg_t  policy_cfg
);

  // ------------------------------
  // interconnect
  // ------------------------------

  // masks of the requesting domain
  cache_pkg::way_mask_t                          fillmap;
  cache_pkg::way_mask_t                          hitmap;

  // indexed set contents
  cache_pkg::tag_entry_t [`CACHE_WAYS-1:0]       tags;
  logic [`CACHE_WAYS-1:0][`CACHE_LINE_BITS-1:0]  lines;
  logic [`CACHE_WAYS-1:0][`CACHE_WAY_BITS-1:0]   ages;

  // lookup and replacement results
  logic                                          hit;
  logic [`CACHE_WAY_BITS-1:0]                    hit_way;
  logic [`CACHE_WAY_BITS-1:0]                    victim_way;
  logic                                          victim_dirty;

  // store write controls
  logic [`CACHE_WAY_BITS-1:0]                    way;
  logic                                          tag_we;
  cache_pkg::tag_entry_t                         tag_wdata;
  logic                                          data_we;
  logic [`CACHE_LINE_BITS-1:0]                   line_wdata;
  logic                                          lru_touch;
  logic [`CACHE_INDEX_BITS-1:0]                  index;

  dawg_policy_regs u_policy (
    .clk     (clk),
    .rst     (rst),
    .cfg     (policy_cfg),
    .domain  (cpu_req.domain),
    .fillmap (fillmap),
    .hitmap  (hitmap)
  );

  cache_set_store u_store (
    .clk        (clk),
    .rst        (rst),
    .index      (index),
    .tags       (tags),
    .lines      (lines),
    .ages       (ages),
    .way        (way),
    .tag_we     (tag_we),
    .tag_wdata  (tag_wdata),
    .data_we    (data_we),
    .line_wdata (line_wdata),
    .lru_touch  (lru_touch),
    .fillmap    (fillmap)
  );

  // lookup and victim search run side by side on the same set
  hit_lookup u_hit (
    .tags    (tags),
    .req_tag (cpu_req.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS]),
    .hitmap  (hitmap),
    .hit     (hit),
    .hit_way (hit_way)
  );

  victim_select u_victim (
    .tags         (tags),
    .ages         (ages),
    .fillmap      (fillmap),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty)
  );

  cache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .cpu_req      (cpu_req),
    .cpu_res      (cpu_res),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .tags         (tags),
    .lines        (lines),
    .way          (way),
    .tag_we       (tag_we),
    .tag_wdata    (tag_wdata),
    .data_we      (data_we),
    .line_wdata   (line_wdata),
    .lru_touch    (lru_touch),
    .index        (index)
  );

endmodule

`default_nettype wire

//--- design/dawg_policy_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module dawg_policy_regs (
  input  wire                           clk,
  input  wire                           rst,
  input  var cache_pkg::policy_cfg_t    cfg,
  input  wire [`CACHE_DOMAIN_BITS-1:0]  domain,
  output cache_pkg::way_mask_t          fillmap,
  output cache_pkg::way_mask_t          hitmap
);
  import cache_pkg::*;

  // one mask pair per protection domain
  way_mask_t fill_q [`CACHE_DOMAINS];
  way_mask_t hit_q  [`CACHE_DOMAINS];

  // ------------------------------
  // policy table
  // ------------------------------

  // all masks zero out of reset, so nothing may fill until configured
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int d = 0; d < `CACHE_DOMAINS; d++) begin
        fill_q[d] <= '0;
        hit_q[d]  <= '0;
      end
    end else if (cfg.we) begin
      fill_q[cfg.domain] <= cfg.fillmap;
      hit_q[cfg.domain]  <= cfg.hitmap;
    end
  end

  // masks of the requesting domain
  assign fillmap = fill_q[domain];
  assign hitmap  = hit_q[domain];

endmodule

`default_nettype wire

//--- design/hit_lookup.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module hit_lookup (
  input  var cache_pkg::tag_entry_t [`CACHE_WAYS-1:0]  tags,
  input  wire [`CACHE_TAG_BITS-1:0]                    req_tag,
  input  var cache_pkg::way_mask_t                     hitmap,
  output logic                                         hit,
  output logic [`CACHE_WAY_BITS-1:0]                   hit_way
);
  import cache_pkg::*;

  // ways that match and are visible to the domain
  way_mask_t match;

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      // copies in ways outside the hitmap stay invisible
      match[w] = tags[w].valid && (tags[w].tag == req_tag) && hitmap[w];
    end
  end

  assign hit = |match;

  // priority encode, lowest matching way wins
  always_comb begin
    hit_way = '0;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (match[w]) begin
        hit_way = w[`CACHE_WAY_BITS-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/victim_select.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module victim_select (
  input  var cache_pkg::tag_entry_t [`CACHE_WAYS-1:0]  tags,
  input  wire [`CACHE_WAYS-1:0][`CACHE_WAY_BITS-1:0]   ages,
  input  var cache_pkg::way_mask_t                     fillmap,
  output logic [`CACHE_WAY_BITS-1:0]                   victim_way,
  output logic                                         victim_dirty
);
  import cache_pkg::*;

  // invalid ways the domain may fill
  way_mask_t                  free_ways;
  logic [`CACHE_WAY_BITS-1:0] free_way;
  // oldest way inside the fillmap
  logic [`CACHE_WAY_BITS-1:0] old_way;
  logic [`CACHE_WAY_BITS-1:0] old_age;
  logic                       seen;

  // ------------------------------
  // first choice, lowest invalid way
  // ------------------------------

  always_comb begin
    free_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      free_ways[w] = fillmap[w] && !tags[w].valid;
    end
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (free_ways[w]) begin
        free_way = w[`CACHE_WAY_BITS-1:0];
      end
    end
  end

  // ------------------------------
  // second choice, oldest way
  // ------------------------------

  always_comb begin
    old_way = '0;
    old_age = '0;
    seen    = 1'b0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      // first fillmap way seeds the search, so a single way still wins
      // strict compare keeps the lower way on ties
      if (fillmap[w] && (!seen || ages[w] > old_age)) begin
        seen    = 1'b1;
        old_age = ages[w];
        old_way = w[`CACHE_WAY_BITS-1:0];
      end
    end
  end

  assign victim_way   = (|free_ways) ? free_way : old_way;

  // a valid dirty victim needs a write-back before the refill
  assign victim_dirty = tags[victim_way].valid && tags[victim_way].dirty;

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/cache_pkg.sv
design/dawg_policy_regs.sv
design/cache_set_store.sv
design/hit_lookup.sv
design/victim_select.sv
design/cache_ctrl.sv
design/dawg_cache_top.sv
test/cache_properties.sv
test/dawg_cache_tb.sv

//--- test/cache_patterns.txt
// memory word at byte address a reads a ^ 5a5a5a5a until its line is written back
// op dom rw addr data exp_word exp_reqs exp_wb (op 0 config, addr fillmap, data hitmap)
// exp_wb ffffffff means no write-back, write rows leave exp_word unchecked
// domain 0 may use every way
0 0 0 0000000f 0000000f 00000000 0 00000000
// read and write hits in set 1
1 0 0 00001010 00000000 5a5a4a4a 1 ffffffff
1 0 0 00001010 00000000 5a5a4a4a 0 ffffffff
1 0 1 00001014 deadbeef 00000000 0 ffffffff
1 0 0 00001014 00000000 deadbeef 0 ffffffff
// dirty eviction in set 2, the fifth write evicts the oldest line
1 0 1 00000120 11111111 00000000 1 ffffffff
1 0 1 00000220 22222222 00000000 1 ffffffff
1 0 1 00000320 33333333 00000000 1 ffffffff
1 0 1 00000420 44444444 00000000 1 ffffffff
1 0 1 00000520 55555555 00000000 2 00000120
1 0 0 00000120 00000000 11111111 2 00000220
1 0 0 00000520 00000000 55555555 0 ffffffff
// domain 0 gets ways 0 and 1, domain 1 gets ways 2 and 3
0 0 0 00000003 00000003 00000000 0 00000000
0 1 0 0000000c 0000000c 00000000 0 00000000
// fill confinement in set 3
1 0 0 00000130 00000000 5a5a5b6a 1 ffffffff
1 0 0 00000230 00000000 5a5a586a 1 ffffffff
1 1 0 00000330 00000000 5a5a596a 1 ffffffff
1 1 0 00000430 00000000 5a5a5e6a 1 ffffffff
1 1 0 00000530 00000000 5a5a5f6a 1 ffffffff
1 0 0 00000130 00000000 5a5a5b6a 0 ffffffff
1 0 0 00000230 00000000 5a5a586a 0 ffffffff
// hit isolation in set 4
1 1 0 00000140 00000000 5a5a5b1a 1 ffffffff
1 0 0 00000140 00000000 5a5a5b1a 1 ffffffff
1 0 0 00000140 00000000 5a5a5b1a 0 ffffffff
1 1 0 00000140 00000000 5a5a5b1a 0 ffffffff
// lru order A B A C inside ways 0 and 1 of set 5
1 0 0 00000150 00000000 5a5a5b0a 1 ffffffff
1 0 0 00000250 00000000 5a5a580a 1 ffffffff
1 0 0 00000150 00000000 5a5a5b0a 0 ffffffff
1 0 0 00000350 00000000 5a5a590a 1 ffffffff
1 0 0 00000150 00000000 5a5a5b0a 0 ffffffff
1 0 0 00000250 00000000 5a5a580a 1 ffffffff
// swap the partitions at run time
0 0 0 0000000c 0000000c 00000000 0 00000000
0 1 0 00000003 00000003 00000000 0 00000000
// set 6 fills follow the new masks
1 0 0 00000160 00000000 5a5a5b3a 1 ffffffff
1 1 0 00000260 00000000 5a5a583a 1 ffffffff
1 1 0 00000360 00000000 5a5a593a 1 ffffffff
1 1 0 00000460 00000000 5a5a5e3a 1 ffffffff
1 0 0 00000160 00000000 5a5a5b3a 0 ffffffff
1 1 0 00000260 00000000 5a5a583a 1 ffffffff

//--- test/cache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cache_properties (
  input wire                          clk,
  input wire                          rst,
  input var cache_pkg::cpu_req_t      cpu_req,
  input var cache_pkg::cpu_res_t      cpu_res,
  input var cache_pkg::mem_req_t      mem_req,
  input var cache_pkg::mem_rsp_t      mem_rsp,
  input var cache_pkg::way_mask_t     fillmap,
  input var cache_pkg::way_mask_t     hitmap
);

  // number of failed assertions so far
  int assert_failures = 0;

  // ------------------------------
  // port protocol
  // ------------------------------

  // refill lines may still be unknown, so data is only held for write-backs
  mem_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req.rw) &&
      $stable(mem_req.addr) && (!mem_req.rw || $stable(mem_req.data)))
    else begin
      $error("memory request changed before its response");
      assert_failures++;
    end

  cpu_req_stable: assert property (@(posedge clk) disable iff (rst)
    cpu_req.valid && !cpu_res.ready |=> $stable(cpu_req))
    else begin
      $error("cpu request changed before ready");
      assert_failures++;
    end

  // a refill needs a fill way that the domain can also hit in
  policy_legal: assert property (@(posedge clk) disable iff (rst)
    $rose(cpu_req.valid) |-> (fillmap != '0) && ((fillmap & ~hitmap) == '0))
    else begin
      $error("access from a domain with an empty or uncovered fillmap");
      assert_failures++;
    end

endmodule

bind dawg_cache_top cache_properties u_props (
  .clk     (clk),
  .rst     (rst),
  .cpu_req (cpu_req),
  .cpu_res (cpu_res),
  .mem_req (mem_req),
  .mem_rsp (mem_rsp),
  .fillmap (fillmap),
  .hitmap  (hitmap)
);

`default_nettype wire

//--- test/dawg_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module dawg_cache_tb;
  import cache_pkg::*;

  localparam int          clk_period     = 100;
  localparam int          reset_cycles   = 8;
  localparam int          max_rows       = 64;
  localparam int          row_fields     = 8;
  localparam int          cycles_per_row = 24;
  // marks unused rows and accesses with no write-back
  localparam logic [31:0] unset_word     = 32'hffff_ffff;
  localparam logic [31:0] fill_key       = 32'h5a5a_5a5a;

  logic        clk;
  logic        rst;
  cpu_req_t    cpu_req;
  cpu_res_t    cpu_res;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  policy_cfg_t policy_cfg;

  // pattern rows, 8 words each
  logic [31:0] pat [0:max_rows*row_fields-1];
  // lines written back by the cache, by line address
  logic [`CACHE_LINE_BITS-1:0] mem_lines [logic [31:0]];

  int seed;
  int errors;
  int tests;
  int num_rows;
  int cycle_count;
  int cycle_limit;
  // memory activity of the current access
  int       req_count;
  logic     wb_seen;
  mem_req_t wb_req;
  // a due write-back must come before the refill
  mem_req_t first_req;

  dawg_cache_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .cpu_req    (cpu_req),
    .cpu_res    (cpu_res),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .policy_cfg (policy_cfg)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period/2) clk = ~clk;
    end
  end

  // ------------------------------
  // timeout
  // ------------------------------

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the cache stopped answering", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ------------------------------
  // memory model
  // ------------------------------

  // untouched memory holds a ^ key in the word at byte address a
  function automatic logic [`CACHE_LINE_BITS-1:0] fill_line(input logic [31:0] line_addr);
    logic [`CACHE_LINE_BITS-1:0] line;
    for (int i = 0; i < 4; i++) begin
      line[32*i +: 32] = (line_addr + 32'(4*i)) ^ fill_key;
    end
    return line;
  endfunction

  function automatic logic [`CACHE_LINE_BITS-1:0] line_at(input logic [31:0] line_addr);
    if (mem_lines.exists(line_addr)) begin
      return mem_lines[line_addr];
    end
    return fill_line(line_addr);
  endfunction

  initial begin
    int       delay;
    mem_req_t cur;
    mem_rsp = '0;
    forever begin
      @(posedge clk);
      #1;
      mem_rsp = '0;
      if (!rst && mem_req.valid) begin
        cur       = mem_req;
        req_count = req_count + 1;
        if (req_count == 1) begin
          first_req = cur;
        end
        if (cur.rw) begin
          wb_seen = 1'b1;
          wb_req  = cur;
        end
        // answer 1 to 4 cycles later
        delay = 1 + ($unsigned($random(seed)) % 4);
        repeat (delay) @(posedge clk);
        #1;
        mem_rsp.ready = 1'b1;
        if (cur.rw) begin
          mem_lines[cur.addr] = cur.data;
        end else begin
          mem_rsp.data = line_at(cur.addr);
        end
      end
    end
  end

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_res(input string name, input cpu_res_t exp, input cpu_res_t got,
                           input logic use_data);
    if (got.ready !== exp.ready) begin
      $display("[ERROR] %s.ready expected %h got %h", name, exp.ready, got.ready);
      errors++;
    end
    if (use_data && got.data !== exp.data) begin
      $display("[ERROR] %s.data expected %h got %h", name, exp.data, got.data);
      errors++;
    end
  endtask

  task automatic check_mem(input string name, input mem_req_t exp, input mem_req_t got);
    if (got.rw !== exp.rw) begin
      $display("[ERROR] %s.rw expected %h got %h", name, exp.rw, got.rw);
      errors++;
    end
    if (got.addr !== exp.addr) begin
      $display("[ERROR] %s.addr expected %h got %h", name, exp.addr, got.addr);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp) begin
      $display("[ERROR] %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic wait_ready(output cpu_res_t res);
    @(negedge clk);
    while (!cpu_res.ready) begin
      @(negedge clk);
    end
    res = cpu_res;
  endtask

  // a hit answers in the compare cycle, one cycle after idle sees valid
  task automatic sample_hit(output cpu_res_t res);
    repeat (2) @(negedge clk);
    res = cpu_res;
  endtask

  // ------------------------------
  // pattern player
  // ------------------------------

  initial begin
    int       base;
    int       row_errors;
    cpu_res_t exp_res;
    cpu_res_t got_res;
    mem_req_t exp_wb;
    seed        = 76;
    errors      = 0;
    tests       = 0;
    cycle_count = 0;
    req_count   = 0;
    wb_seen     = 1'b0;
    wb_req      = '0;
    first_req   = '0;
    cpu_req     = '0;
    policy_cfg  = '0;
    rst         = 1'b1;
    foreach (pat[i]) begin
      pat[i] = unset_word;
    end
    $readmemh("test/cache_patterns.txt", pat);
    num_rows = 0;
    while (num_rows < max_rows && pat[num_rows*row_fields] !== unset_word) begin
      num_rows++;
    end
    cycle_limit = num_rows * cycles_per_row + reset_cycles;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int r = 0; r < num_rows; r++) begin
      base       = r * row_fields;
      row_errors = errors;
      @(posedge clk);
      #1;
      if (pat[base] == 0) begin
        // policy write, masks live one cycle later
        policy_cfg.we      = 1'b1;
        policy_cfg.domain  = pat[base+1][`CACHE_DOMAIN_BITS-1:0];
        policy_cfg.fillmap = pat[base+3][`CACHE_WAYS-1:0];
        policy_cfg.hitmap  = pat[base+4][`CACHE_WAYS-1:0];
        @(posedge clk);
        #1;
        $display("row %0d config domain %0d fillmap %b hitmap %b", r,
                 policy_cfg.domain, policy_cfg.fillmap, policy_cfg.hitmap);
        policy_cfg = '0;
      end else begin
        req_count      = 0;
        wb_seen        = 1'b0;
        cpu_req.valid  = 1'b1;
        cpu_req.rw     = pat[base+2][0];
        cpu_req.domain = pat[base+1][`CACHE_DOMAIN_BITS-1:0];
        cpu_req.addr   = pat[base+3];
        cpu_req.data   = pat[base+4];
        // rows without memory traffic are hits with fixed latency
        if (pat[base+6] == 0) begin
          sample_hit(got_res);
        end else begin
          wait_ready(got_res);
        end
        exp_res.ready = 1'b1;
        exp_res.data  = pat[base+5];
        // write responses carry no defined word
        check_res("cpu_res", exp_res, got_res, !cpu_req.rw);
        check_count("mem_req count", pat[base+6], req_count);
        if (pat[base+7] === unset_word) begin
          if (wb_seen) begin
            $display("row %0d wrote back line %h although no write-back was due",
                     r, wb_req.addr);
            errors++;
          end
        end else if (!wb_seen) begin
          $display("row %0d expected a write-back of line %h but none came", r, pat[base+7]);
          errors++;
        end else begin
          exp_wb       = '0;
          exp_wb.valid = 1'b1;
          exp_wb.rw    = 1'b1;
          exp_wb.addr  = pat[base+7];
          check_mem("mem_req", exp_wb, first_req);
        end
        $display("row %0d %s domain %0d addr %h %s", r, cpu_req.rw ? "write" : "read",
                 cpu_req.domain, cpu_req.addr, (errors == row_errors) ? "ok" : "failed");
        @(posedge clk);
        #1;
        cpu_req = '0;
      end
      tests++;
    end

    // failed assertions of the bound checker
    errors = errors + u_dut.u_props.assert_failures;
    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
